/* all.f */
logic/adpcmb_pkg.sv
logic/adpcmb_nibble_decode.sv
logic/adpcmb_serial_div.sv
logic/adpcmb_interpol.sv
logic/adpcmb_volume.sv
logic/adpcmb_channel.sv
verification/adpcmb_channel_tb.sv

/* logic/adpcmb_channel.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One ADPCM-B voice channel. Nibbles come in on a req/ack handshake
// and a volume-scaled 16-bit sample goes out at the tick rate.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module adpcmb_channel #(
    parameter int DIV_W = 16                      // Divider width, at least the sample width.
) (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   tick,     // Output sample rate strobe.
    input  logic                                   req,
    input  logic [adpcmb_pkg::nibble_w-1:0]        nibble,
    input  logic [7:0]                             volume,
    output logic                                   ack,
    output logic signed [adpcmb_pkg::sample_w-1:0] pcm_out
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stage links.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    logic                                   adv;         // New sample on the way.
    logic signed [adpcmb_pkg::sample_w-1:0] pcm_dec;     // Decoded target sample.
    logic signed [adpcmb_pkg::sample_w-1:0] pcm_inter;   // Interpolated sample.

    // Decode. The handshake and the ADPCM rule live here.
    adpcmb_nibble_decode u_decode (
        .clk     (clk),
        .rst     (rst),
        .tick    (tick),
        .req     (req),
        .nibble  (nibble),
        .ack     (ack),
        .adv     (adv),
        .pcm_dec (pcm_dec)
    );

    // Execute. It moves one clock after each tick.
    adpcmb_interpol #(
        .DIV_W     (DIV_W)
    ) u_interpol (
        .clk       (clk),
        .rst       (rst),
        .tick      (tick),
        .adv       (adv),
        .pcm_dec   (pcm_dec),
        .pcm_inter (pcm_inter)
    );

    // Result. The output settles two clocks after the tick.
    adpcmb_volume u_volume (
        .clk       (clk),
        .rst       (rst),
        .tick      (tick),
        .volume    (volume),
        .pcm_inter (pcm_inter),
        .pcm_out   (pcm_out)
    );

endmodule

/* logic/adpcmb_interpol.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Execute stage. Measures the ticks between advances and walks the
// output linearly from the last sample to the new target.
// The step is the sample gap divided by the span in a serial divider.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module adpcmb_interpol #(
    parameter int DIV_W = 16
) (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   tick,
    input  logic                                   adv,
    input  logic signed [adpcmb_pkg::sample_w-1:0] pcm_dec,
    output logic signed [adpcmb_pkg::sample_w-1:0] pcm_inter
);

    localparam int SW = adpcmb_pkg::sample_w;

    logic                            tick_d;     // Tick delayed to line up with adv.
    logic                            adv_d;      // Clock on which pcm_dec is new.
    logic [adpcmb_pkg::count_w-1:0]  cnt;        // Ticks since the last advance.
    logic [adpcmb_pkg::count_w:0]    span;       // Latched count, zero read as 16.
    logic signed [SW-1:0]            last;       // Start point of the segment.
    logic signed [SW-1:0]            target;     // End point of the segment.
    logic signed [SW:0]              delta;      // New target minus last.
    logic [SW:0]                     delta_neg;
    logic [SW-1:0]                   delta_abs;
    logic                            start;
    logic [DIV_W-1:0]                dividend;
    logic [DIV_W-1:0]                divisor;
    logic                            dir_pend;   // Sign waiting for the quotient.
    logic [DIV_W-1:0]                quotient;
    logic                            done;
    logic [SW-1:0]                   step;       // Increment per tick.
    logic                            dir;        // High when moving down.
    logic signed [SW+1:0]            moved;
    logic signed [SW-1:0]            next_inter;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Segment set-up.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign delta     = pcm_dec - last;
    assign delta_neg = -delta;
    assign delta_abs = delta[SW] ? delta_neg[SW-1:0] : delta[SW-1:0];   // Up to 65535.

    assign divisor = DIV_W'(span);                // Never zero.

    // One step toward the target. The result stops at the target
    // so a late advance leaves the output parked there.
    assign moved = dir ? (pcm_inter - $signed({1'b0, step}))
                       : (pcm_inter + $signed({1'b0, step}));

    always_comb begin
        if (!dir && (moved > target)) begin
            next_inter = target;
        end else if (dir && (moved < target)) begin
            next_inter = target;
        end else begin
            next_inter = moved[SW-1:0];
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Registers.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (rst) begin
            tick_d    <= 1'b0;
            adv_d     <= 1'b0;
            cnt       <= adpcmb_pkg::count_w'(1);
            span      <= (adpcmb_pkg::count_w + 1)'(1);
            last      <= '0;
            target    <= '0;
            pcm_inter <= '0;
            start     <= 1'b0;
            step      <= '0;
            dir       <= 1'b0;
        end else begin
            tick_d <= tick;
            adv_d  <= adv;
            start  <= adv_d;                      // Divider runs once per advance.
            if (tick_d) begin
                if (adv) begin
                    span      <= (cnt == '0) ? (adpcmb_pkg::count_w + 1)'(16) : {1'b0, cnt};
                    cnt       <= adpcmb_pkg::count_w'(1);
                    last      <= target;
                    pcm_inter <= target;          // Finish the old segment exactly.
                end else begin
                    cnt       <= cnt + 1'b1;      // Wraps from 15 to 0.
                    pcm_inter <= next_inter;
                end
            end
            if (adv_d) begin
                target <= pcm_dec;
            end
            // The quotient is ready well before the next tick.
            if (done) begin
                step <= quotient[SW-1:0];
                dir  <= dir_pend;
            end
        end
    end

    // Divider operands are payload and load on the set-up clock.
    always_ff @(posedge clk) begin
        if (adv_d) begin
            dividend <= DIV_W'(delta_abs);
            dir_pend <= delta[SW];
        end
    end

    adpcmb_serial_div #(
        .DIV_W    (DIV_W)
    ) u_div (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .dividend (dividend),
        .divisor  (divisor),
        .quotient (quotient),
        .done     (done)
    );

endmodule

/* logic/adpcmb_nibble_decode.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ADPCM-B decode stage. Takes one nibble per four-phase handshake
// on a tick clock and updates the predicted sample and step size.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module adpcmb_nibble_decode (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   tick,
    input  logic                                   req,
    input  logic [adpcmb_pkg::nibble_w-1:0]        nibble,
    output logic                                   ack,
    output logic                                   adv,
    output logic signed [adpcmb_pkg::sample_w-1:0] pcm_dec
);

    logic                             take;       // Nibble accepted on this clock.
    logic [adpcmb_pkg::nibble_w-1:0]  nib_q;      // Captured code.
    logic [adpcmb_pkg::step_w-1:0]    step;       // Current step size.
    logic [2:0]                       mag;
    logic                             sign;
    logic [18:0]                      diff_full;  // (2 * mag + 1) * step.
    logic [15:0]                      diff;       // Sample increment.
    logic signed [17:0]               sum;        // Unsaturated new sample.
    logic signed [adpcmb_pkg::sample_w-1:0] sum_sat;
    logic [21:0]                      step_prod;  // step * factor.
    logic [adpcmb_pkg::step_w-1:0]    step_scaled;
    logic [adpcmb_pkg::step_w-1:0]    step_next;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Handshake.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // A nibble is only taken on a tick with req high and ack still low.
    assign take = tick & req & ~ack;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sample and step arithmetic.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign sign = nib_q[adpcmb_pkg::nibble_w-1];  // Top bit selects subtract.
    assign mag  = nib_q[2:0];

    // The largest product is 15 * 24576, which fits in 19 bits.
    assign diff_full = {mag, 1'b1} * step;
    assign diff      = diff_full[18:3];           // Divide by eight.

    assign sum = sign ? (pcm_dec - $signed({2'b00, diff}))
                      : (pcm_dec + $signed({2'b00, diff}));

    // Clip the new sample to the signed 16-bit range.
    always_comb begin
        if (sum > 18'sd32767) begin
            sum_sat = 16'sh7fff;
        end else if (sum < -18'sd32768) begin
            sum_sat = 16'sh8000;
        end else begin
            sum_sat = sum[adpcmb_pkg::sample_w-1:0];
        end
    end

    // 24576 * 153 stays below 2^22, so the scaled step fits 16 bits.
    assign step_prod   = step * adpcmb_pkg::step_factor[mag];
    assign step_scaled = step_prod[21:6];         // Divide by 64.

    always_comb begin
        if (step_scaled < adpcmb_pkg::step_min) begin
            step_next = adpcmb_pkg::step_w'(adpcmb_pkg::step_min);
        end else if (step_scaled > adpcmb_pkg::step_max) begin
            step_next = adpcmb_pkg::step_w'(adpcmb_pkg::step_max);
        end else begin
            step_next = step_scaled;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Registers.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (rst) begin
            ack     <= 1'b0;
            adv     <= 1'b0;
            pcm_dec <= '0;
            step    <= adpcmb_pkg::step_w'(adpcmb_pkg::step_min);
        end else begin
            adv <= take;                          // One pulse per accepted nibble.
            if (take) begin
                ack <= 1'b1;
            end else if (!req) begin
                ack <= 1'b0;                      // Falls the clock after req is low.
            end
            // The update runs while adv is high, so pcm_dec is new from the next clock.
            if (adv) begin
                pcm_dec <= sum_sat;
                step    <= step_next;
            end
        end
    end

    // The code is payload and only needs a load enable.
    always_ff @(posedge clk) begin
        if (take) begin
            nib_q <= nibble;
        end
    end

endmodule

/* logic/adpcmb_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared constants for the ADPCM-B voice channel.
// Modules refer to these by scoped name from the package.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package adpcmb_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Data widths.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int sample_w = 16;       // Signed PCM sample.
    localparam int nibble_w = 4;        // One ADPCM code, sign plus three magnitude bits.
    localparam int step_w   = 16;       // Unsigned adaptive step size.
    localparam int count_w  = 4;        // Ticks between advances. Zero means sixteen.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Step-size adaptation.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int step_min = 127;      // Also the step after reset.
    localparam int step_max = 24576;

    // The new step is step * step_factor[magnitude] / 64.
    // Small codes shrink the step and large codes grow it.
    localparam logic [7:0] step_factor [0:7] = '{
        8'd57,
        8'd57,
        8'd57,
        8'd57,
        8'd77,
        8'd102,
        8'd128,
        8'd153
    };

endpackage

/* logic/adpcmb_serial_div.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Unsigned restoring divider. A start pulse loads the operands and
// one quotient bit is produced per clock until done pulses.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module adpcmb_serial_div #(
    parameter int DIV_W = 16
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             start,
    input  logic [DIV_W-1:0] dividend,
    input  logic [DIV_W-1:0] divisor,
    output logic [DIV_W-1:0] quotient,
    output logic             done
);

    localparam int CNT_W = $clog2(DIV_W + 1);

    logic [DIV_W-1:0] rem;              // Partial remainder.
    logic [DIV_W-1:0] den;              // Latched divisor.
    logic [DIV_W:0]   partial;          // Remainder with the next dividend bit.
    logic [DIV_W:0]   trial;            // Partial minus divisor.
    logic             fits;
    logic [CNT_W-1:0] cnt;              // Bits still to produce.
    logic             busy;

    // The dividend shifts out of the top of the quotient register
    // while the quotient bits shift in at the bottom.
    assign partial = {rem, quotient[DIV_W-1]};
    assign trial   = partial - {1'b0, den};

    // Since rem < den, a borrow always shows in the top bit of trial.
    assign fits = ~trial[DIV_W];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sequencing.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                cnt  <= CNT_W'(DIV_W);
            end else if (busy) begin
                cnt <= cnt - 1'b1;
                if (cnt == CNT_W'(1)) begin
                    busy <= 1'b0;                 // Last bit is going in now.
                    done <= 1'b1;
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Datapath.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (start) begin
            rem      <= '0;
            den      <= divisor;
            quotient <= dividend;
        end else if (busy) begin
            rem      <= fits ? trial[DIV_W-1:0] : partial[DIV_W-1:0];
            quotient <= {quotient[DIV_W-2:0], fits};
        end
    end

endmodule

/* logic/adpcmb_volume.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Result stage. Scales the interpolated sample by an 8-bit volume
// and registers it one clock after the execute stage moves.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module adpcmb_volume (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   tick,
    input  logic [7:0]                             volume,
    input  logic signed [adpcmb_pkg::sample_w-1:0] pcm_inter,
    output logic signed [adpcmb_pkg::sample_w-1:0] pcm_out
);

    localparam int SW = adpcmb_pkg::sample_w;

    logic [1:0]           tick_q;                 // Tick delayed by one and two clocks.
    logic signed [SW+8:0] scaled;                 // Sample times volume.

    // The volume is unsigned. A zero top bit keeps it positive.
    assign scaled = pcm_inter * $signed({1'b0, volume});

    // The execute stage moves on tick_q[0], so the new sample is
    // registered here on the clock after that.
    always_ff @(posedge clk) begin
        if (rst) begin
            tick_q  <= 2'b00;
            pcm_out <= '0;
        end else begin
            tick_q <= {tick_q[0], tick};
            if (tick_q[1]) begin
                // Dropping the low byte of a two's complement word floors it.
                pcm_out <= scaled[SW+7:8];
            end
        end
    end

endmodule

/* verification/adpcmb_channel_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the ADPCM-B voice channel. It sends nibbles over the
// req/ack handshake with random spans between advances. Each output
// sample is checked against a model of decode, interpolation and volume.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module adpcmb_channel_tb;

    localparam int tick_period = 24;                          // Clocks per output sample.
    localparam int max_ticks   = 2000;
    localparam int cycle_limit = max_ticks * tick_period + 1000;
    localparam int step_lo     = 127;                         // Smallest step size.
    localparam int step_hi     = 24576;                       // Largest step size.

    logic               clk = 1'b0;
    logic               rst;
    logic               tick;
    logic               req;
    logic [3:0]         nibble;
    logic [7:0]         volume;
    logic               ack;
    logic signed [15:0] pcm_out;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model state.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    int         m_sample;                                     // Decoded sample.
    int         m_step;                                       // Adaptive step size.
    int         m_target;                                     // End point of the segment.
    int         m_last;                                       // Start point of the segment.
    int         m_inter;                                      // Interpolated sample.
    int         m_istep;                                      // Increment per tick.
    int         m_cnt;                                        // Ticks since the last advance.
    int         m_span;
    logic       m_dir;                                        // High when moving down.
    int         tick_cnt;                                     // Ticks seen so far.
    int         last_adv;                                     // Tick index of the last advance.
    int         cycles;
    int         pend;                                         // Clocks until the output is due.
    int         exp_inter;
    int         exp_out;
    logic       exp_adv;
    logic [7:0] vol_prev;                                     // Volume seen by the last edge.
    logic       rst_prev;
    logic       ack_prev;
    logic       req_prev;
    logic       tick_prev;
    logic [3:0] nibble_prev;
    logic       failed;
    string      test_name;

    adpcmb_channel #(
        .DIV_W   (16)
    ) dut (
        .clk     (clk),
        .rst     (rst),
        .tick    (tick),
        .req     (req),
        .nibble  (nibble),
        .volume  (volume),
        .ack     (ack),
        .pcm_out (pcm_out)
    );

    initial begin
        forever #10 clk = ~clk;                               // Period of 20.
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Failure reporting.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic stop_with_failure;
        failed = 1'b1;
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic report_mismatch(input string test, input string what,
                                   input int expected, input int actual);
        $display("error %s %s expected %0d actual %0d", test, what, expected, actual);
        stop_with_failure();
    endtask

    task automatic report_fault(input string msg);
        $display("%s", msg);
        stop_with_failure();
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Model rules.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Step multiplier per magnitude, in 64ths.
    function automatic int factor_for(input int mag);
        case (mag)
            4:       return 77;
            5:       return 102;
            6:       return 128;
            7:       return 153;
            default: return 57;                               // Codes 0 to 3 shrink the step.
        endcase
    endfunction

    function automatic int adapt_step(input int step, input int mag);
        int s;
        s = (step * factor_for(mag)) / 64;
        if (s < step_lo) s = step_lo;
        if (s > step_hi) s = step_hi;
        return s;
    endfunction

    function automatic int next_sample(input int sample, input int step, input logic [3:0] code);
        int mag;
        int diff;
        int s;
        mag  = code[2:0];
        diff = ((2 * mag + 1) * step) / 8;
        s    = code[3] ? (sample - diff) : (sample + diff);   // Top bit means subtract.
        if (s > 32767) s = 32767;
        if (s < -32768) s = -32768;
        return s;
    endfunction

    // Floor of sample times volume over 256.
    function automatic int scale_volume(input int sample, input int vol);
        int p;
        p = sample * vol;
        return p >>> 8;
    endfunction

    task automatic reset_model;
        m_sample = 0;
        m_step   = step_lo;
        m_target = 0;
        m_last   = 0;
        m_inter  = 0;
        m_istep  = 0;
        m_cnt    = 1;
        m_span   = 1;
        m_dir    = 1'b0;
        pend     = 0;
    endtask

    // An advance tick closes the old segment and opens a new one.
    task automatic advance_model(input logic [3:0] code);
        m_span   = (m_cnt == 0) ? 16 : m_cnt;                 // A wrapped count means 16.
        m_cnt    = 1;
        m_last   = m_target;
        m_inter  = m_target;
        m_sample = next_sample(m_sample, m_step, code);
        m_step   = adapt_step(m_step, code[2:0]);
        m_target = m_sample;
        m_dir    = (m_target < m_last);
        m_istep  = (m_dir ? (m_last - m_target) : (m_target - m_last)) / m_span;
    endtask

    // Any other tick moves one step and parks at the target.
    task automatic walk_model;
        int moved;
        m_cnt = (m_cnt + 1) % 16;
        if (m_dir) begin
            moved = m_inter - m_istep;
            if (moved < m_target) moved = m_target;
        end else begin
            moved = m_inter + m_istep;
            if (moved > m_target) moved = m_target;
        end
        m_inter = moved;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Output checking, on the falling edge where everything is settled.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(negedge clk) begin
        if (rst) begin
            reset_model();
            assert (ack == 1'b0) else report_mismatch("reset", "ack", 0, ack);
            assert (pcm_out == 16'sd0) else report_mismatch("reset", "pcm_out", 0, pcm_out);
        end else begin
            if (rst_prev) begin                               // First clock out of reset.
                assert (ack == 1'b0) else report_mismatch("reset", "ack", 0, ack);
                assert (pcm_out == 16'sd0) else report_mismatch("reset", "pcm_out", 0, pcm_out);
            end
            if (pend > 0) begin
                pend = pend - 1;
                if (pend == 0) begin
                    exp_out = scale_volume(exp_inter, vol_prev);
                    assert (pcm_out == exp_out)
                        else report_mismatch(test_name, exp_adv ? "advance" : "interpolation",
                                             exp_out, pcm_out);
                    if (vol_prev == 8'd0) begin
                        assert (pcm_out == 16'sd0)
                            else report_mismatch(test_name, "silent", 0, pcm_out);
                    end
                end
            end
            // The next rising edge samples this tick.
            if (tick) begin
                tick_cnt = tick_cnt + 1;
                exp_adv  = req && !ack;
                if (exp_adv) advance_model(nibble);
                else walk_model();
                exp_inter = m_inter;
                pend      = 3;                                // Output lands two clocks later.
            end
        end
        rst_prev = rst;
        vol_prev = volume;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Handshake checking.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(negedge clk) begin
        if (!rst) begin
            if (ack && !ack_prev) begin
                assert (req_prev && tick_prev)
                    else report_fault("ack rose without req high on a tick clock");
            end
            if (ack_prev && !req_prev) begin
                assert (!ack) else report_fault("ack did not fall one clock after req went low");
            end
            if (ack_prev && req_prev) begin
                assert (ack) else report_fault("ack fell while req was still high");
            end
            if (req && !req_prev) begin
                assert (!ack) else report_fault("req was raised while ack was still high");
            end
            if (req && req_prev) begin
                assert (nibble == nibble_prev) else report_fault("nibble changed while req was high");
            end
        end
        ack_prev    = ack;
        req_prev    = req;
        tick_prev   = tick;
        nibble_prev = nibble;
    end

    // Cycle limit, sized from the longest possible run of ticks.
    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles = cycles + 1;
            if (cycles >= cycle_limit) begin
                $display("timeout after %0d clocks before the sequences finished", cycles);
                stop_with_failure();
            end
        end
    end

    // One tick pulse in every 24 clocks once reset is released.
    initial begin
        tick = 1'b0;
        @(negedge rst);
        forever begin
            repeat (tick_period - 1) @(posedge clk);
            #2 tick = 1'b1;
            @(posedge clk);
            #2 tick = 1'b0;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Producer side of the handshake.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Raise req so that the nibble is taken gap ticks after the last advance.
    task automatic send_nibble(input logic [3:0] code, input int gap);
        while (tick_cnt < last_adv + gap - 1) begin
            @(posedge clk);
            #2;
        end
        nibble = code;
        req    = 1'b1;
        @(posedge clk);
        #2;
        while (!ack) begin
            @(posedge clk);
            #2;
        end
        last_adv = tick_cnt;                                  // Ack rose on this tick.
        req      = 1'b0;
        @(posedge clk);
        #2;
        while (ack) begin
            @(posedge clk);
            #2;
        end
    endtask

    initial begin
        int         seed;
        int         unused_rand;
        int         gap;
        logic [3:0] code;
        rst       = 1'b1;
        req       = 1'b0;
        nibble    = 4'h0;
        volume    = 8'd0;
        failed    = 1'b0;
        tick_cnt  = 0;
        last_adv  = 0;
        rst_prev  = 1'b0;
        test_name = "reset";
        seed        = 32'h8ff950f5;
        unused_rand = $urandom(seed);
        repeat (2) @(posedge clk);
        #2 rst = 1'b0;

        // Random codes with spans of 1 to 8 ticks.
        test_name = "random";
        volume    = 8'd200;
        for (int i = 0; i < 200; i++) begin
            code = $urandom % 16;
            gap  = 1 + ($urandom % 8);
            send_nibble(code, gap);
        end

        // Largest codes both ways. Two long gaps make the tick count wrap.
        test_name = "maximum";
        volume    = 8'd255;
        for (int i = 0; i < 16; i++) begin
            send_nibble(4'h7, (i == 8) ? 16 : 2);
        end
        for (int i = 0; i < 16; i++) begin
            send_nibble(4'hf, (i == 8) ? 18 : 2);
        end

        // Zero codes shrink the step back to the floor.
        test_name = "zero";
        volume    = 8'd128;
        for (int i = 0; i < 50; i++) begin
            send_nibble(4'h0, 1);
        end
        assert (dut.u_decode.step == step_lo)
            else report_fault("zero run did not bring the step to its minimum");

        test_name = "volume";
        for (int v = 0; v < 3; v++) begin
            volume = (v == 0) ? 8'd0 : ((v == 1) ? 8'd128 : 8'd255);
            for (int i = 0; i < 12; i++) begin
                send_nibble($urandom % 16, 3);
            end
        end

        // Let the last segment play out so its outputs are checked.
        repeat (4 * tick_period) @(posedge clk);
        #2;
        if (!failed) begin
            $display("TEST OK");
            $finish;
        end else begin
            stop_with_failure();
        end
    end

endmodule
